//--- Bender.yml
package:
  name: fsab_arbiter

sources:
  # Packages first, then the modules that use them
  - files:
      - verilog/fsab_bus_pkg.sv
      - verilog/fsab_arb_pkg.sv
      - verilog/fsab_req_fifo.sv
      - verilog/fsab_arb_select.sv
      - verilog/fsab_arbiter.sv

  # Testbench, includes its transaction table from dv
  - target: simulation
    include_dirs:
      - dv
    files:
      - dv/fsab_arbiter_tb.sv

//--- dv/fsab_arbiter_tb_table.svh
`ifndef FSAB_ARBITER_TB_TABLE_SVH
`define FSAB_ARBITER_TB_TABLE_SVH

// Columns: device, mode, len, addr, subdid, launch group, bus credits back after the group
// Rows of one group are pushed back to back, then the group's credits return one at a time

typedef struct {
	int dev;
	fsab_bus_pkg::fsab_mode_e mode;
	int len;    // Header len, a read still has one beat
	logic [fsab_bus_pkg::FSAB_ADDR_W-1:0] addr;
	int subdid;
	int group;
	int ret;
} txn_row_t;

localparam int NUM_ROWS = 25;

txn_row_t txn_table [NUM_ROWS] = '{
	// Group 0 spends the bus credits held after reset
	'{0, fsab_bus_pkg::FSAB_WRITE, 1, 31'h0000100, 1, 0, 0},
	'{1, fsab_bus_pkg::FSAB_WRITE, 2, 31'h0000200, 2, 0, 0},
	'{2, fsab_bus_pkg::FSAB_WRITE, 3, 31'h0000300, 3, 0, 0},
	'{3, fsab_bus_pkg::FSAB_WRITE, 4, 31'h0000400, 4, 0, 0},
	// One waiting write per device, released in descending device order
	'{0, fsab_bus_pkg::FSAB_WRITE, 5, 31'h0010000, 5, 1, 0},
	'{1, fsab_bus_pkg::FSAB_WRITE, 6, 31'h0020000, 6, 1, 0},
	'{2, fsab_bus_pkg::FSAB_WRITE, 7, 31'h0030000, 7, 1, 0},
	'{3, fsab_bus_pkg::FSAB_WRITE, 8, 31'h0040000, 8, 1, 4},
	// Reads with odd len fields, then second transactions queued behind them
	'{0, fsab_bus_pkg::FSAB_READ, 1, 31'h1000000, 9, 2, 0},
	'{1, fsab_bus_pkg::FSAB_READ, 4, 31'h1000010, 10, 2, 0},
	'{2, fsab_bus_pkg::FSAB_READ, 8, 31'h1000020, 11, 2, 0},
	'{3, fsab_bus_pkg::FSAB_READ, 2, 31'h1000030, 12, 2, 0},
	'{3, fsab_bus_pkg::FSAB_WRITE, 8, 31'h2000000, 13, 2, 0},
	'{1, fsab_bus_pkg::FSAB_WRITE, 3, 31'h2000100, 14, 2, 0},
	'{0, fsab_bus_pkg::FSAB_WRITE, 6, 31'h2000200, 15, 2, 11}, // Four credits left in stock
	// Free flow while credits are in stock
	'{2, fsab_bus_pkg::FSAB_WRITE, 8, 31'h3000000, 0, 3, 0},
	'{0, fsab_bus_pkg::FSAB_WRITE, 2, 31'h3000040, 1, 3, 0},
	'{3, fsab_bus_pkg::FSAB_READ, 1, 31'h3000080, 2, 3, 0},
	'{1, fsab_bus_pkg::FSAB_WRITE, 5, 31'h30000c0, 3, 3, 2},
	// Two start at once, the rest wait for credits
	'{1, fsab_bus_pkg::FSAB_WRITE, 7, 31'h4000000, 4, 4, 0},
	'{3, fsab_bus_pkg::FSAB_WRITE, 3, 31'h4000100, 5, 4, 0},
	'{0, fsab_bus_pkg::FSAB_READ, 5, 31'h4000200, 6, 4, 0},
	'{2, fsab_bus_pkg::FSAB_WRITE, 4, 31'h4000300, 7, 4, 0},
	'{2, fsab_bus_pkg::FSAB_READ, 1, 31'h4000400, 8, 4, 0},
	'{0, fsab_bus_pkg::FSAB_WRITE, 8, 31'h4000500, 9, 4, 4}
};

int unsigned lcg_state = 46443; // Fixed seed

// Write data and masks
function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

`endif

//--- dv/fsab_arbiter_tb.sv
`timescale 1ns/10ps

// Testbench for the FSAB request arbiter
module fsab_arbiter_tb;

	localparam int DEVS = fsab_arb_pkg::FSAB_DEVICES;
	localparam int DID_W = fsab_bus_pkg::FSAB_DID_W;
	localparam int LEN_W = fsab_bus_pkg::FSAB_LEN_W;
	localparam int DATA_W = fsab_bus_pkg::FSAB_DATA_W;
	localparam int MASK_W = fsab_bus_pkg::FSAB_MASK_W;
	localparam int QUIET_CYCLES = 12; // Idle window that proves nothing else starts

	logic clk = 1'b0;
	logic rst_b;
	logic [DEVS-1:0] dev_valid;
	fsab_bus_pkg::fsab_req_t dev_req [DEVS];
	logic [DEVS-1:0] dev_credit;
	logic bus_valid;
	fsab_bus_pkg::fsab_req_t bus_req;
	logic bus_credit;

	`include "fsab_arbiter_tb_table.svh"

	// Per device, in push order
	fsab_bus_pkg::fsab_req_t exp_beats [DEVS][$];
	int exp_nbeats [DEVS][$];

	int dev_cred [DEVS]; // Credits each device holds
	int pushed_cnt [DEVS];
	int started_dev [DEVS];
	int credit_pulses [DEVS];
	int started_total = 0;
	int returned_total = 0;
	int last_dev = -1; // Device of the newest transaction on the bus
	int errors = 0;
	int faults = 0;

	logic in_txn = 1'b0;
	int cur_did;
	int cur_n;
	int beat_idx;

	fsab_arbiter u_dut (
		.clk        (clk),
		.rst_b      (rst_b),
		.dev_valid  (dev_valid),
		.dev_req    (dev_req),
		.dev_credit (dev_credit),
		.bus_valid  (bus_valid),
		.bus_req    (bus_req),
		.bus_credit (bus_credit)
	);

	always #5 clk = ~clk;

	task automatic check_value(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
		end
	endtask

	// Drive point, 1 ns after the rising edge
	task automatic next_slot();
		@(posedge clk);
		#1;
	endtask

	function automatic int beat_count(input fsab_bus_pkg::fsab_mode_e mode, input int len);
		return (mode == fsab_bus_pkg::FSAB_READ) ? 1 : len;
	endfunction

	function automatic int total_beats();
		int sum;
		sum = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			sum += beat_count(txn_table[r].mode, txn_table[r].len);
		return sum;
	endfunction

	// Pushed but not yet seen on the bus
	function automatic int total_pending();
		int sum;
		sum = 0;
		for (int d = 0; d < DEVS; d++)
			sum += pushed_cnt[d] - started_dev[d];
		return sum;
	endfunction

	// Fixed priority, highest numbered waiting device goes next
	function automatic int highest_pending();
		for (int d = DEVS - 1; d >= 0; d--) begin
			if (pushed_cnt[d] > started_dev[d])
				return d;
		end
		return -1;
	endfunction

	function automatic int bus_credit_model();
		return fsab_arb_pkg::FSAB_BUS_CREDITS + returned_total - started_total;
	endfunction

	task automatic push_txn(input int row);
		int dev;
		int nbeats;
		logic [31:0] rnd_hi;
		logic [31:0] rnd_lo;
		fsab_bus_pkg::fsab_req_t beat;
		dev = txn_table[row].dev % DEVS;
		nbeats = beat_count(txn_table[row].mode, txn_table[row].len);
		while (dev_cred[dev] == 0)
			next_slot(); // No credit, no push
		dev_cred[dev]--;
		exp_nbeats[dev].push_back(nbeats);
		for (int b = 0; b < nbeats; b++) begin
			rnd_hi = lcg_next();
			rnd_lo = lcg_next();
			beat.mode = txn_table[row].mode;
			beat.did = DID_W'(dev);
			beat.subdid = DID_W'(txn_table[row].subdid);
			beat.addr = txn_table[row].addr;
			beat.len = LEN_W'(txn_table[row].len);
			beat.data = DATA_W'({rnd_hi, rnd_lo});
			beat.mask = MASK_W'(rnd_lo >> 11);
			exp_beats[dev].push_back(beat);
			dev_req[dev] = beat;
			dev_valid[dev] = 1'b1;
			next_slot();
		end
		dev_valid[dev] = 1'b0;
		pushed_cnt[dev]++;
	endtask

	task automatic return_credit();
		bus_credit = 1'b1;
		returned_total++;
		next_slot();
		bus_credit = 1'b0;
	endtask

	// Bus idle and either everything sent or out of bus credits
	task automatic wait_quiet();
		while (in_txn || (total_pending() > 0 && bus_credit_model() > 0))
			next_slot();
		repeat (QUIET_CYCLES) next_slot();
		if (total_pending() > 0)
			check_value("transactions started", started_total,
				fsab_arb_pkg::FSAB_BUS_CREDITS + returned_total);
	endtask

	task automatic release_credits(input int count);
		int exp_dev;
		int mark;
		for (int k = 0; k < count; k++) begin
			exp_dev = highest_pending();
			mark = started_total;
			return_credit();
			if (exp_dev >= 0) begin
				while (started_total == mark)
					next_slot();
				check_value("device of released transaction", last_dev, exp_dev);
			end
			wait_quiet(); // Exactly one start per credit
		end
	endtask

	always @(negedge clk) begin : bus_monitor
		fsab_bus_pkg::fsab_req_t exp;
		if (rst_b) begin
			for (int d = 0; d < DEVS; d++) begin
				if (dev_credit[d]) begin
					credit_pulses[d]++;
					dev_cred[d]++;
					if (dev_cred[d] > fsab_arb_pkg::FSAB_DEV_CREDITS) begin
						faults++;
						$display("At %0t ns device %0d got back more credits than it spent",
							$time, d);
					end
				end
			end
			if (bus_valid && !in_txn) begin
				cur_did = int'(bus_req.did);
				if (cur_did >= DEVS || exp_nbeats[cur_did].size() == 0) begin
					faults++;
					$display("At %0t ns a bus beat from device %0d matches no pushed transaction",
						$time, cur_did);
				end else begin
					in_txn = 1'b1;
					cur_n = exp_nbeats[cur_did].pop_front();
					beat_idx = 0;
					started_total++;
					started_dev[cur_did]++;
					last_dev = cur_did;
				end
			end
			if (bus_valid && in_txn) begin
				exp = exp_beats[cur_did].pop_front();
				check_value("bus_req.mode", bus_req.mode, exp.mode);
				check_value("bus_req.did", bus_req.did, exp.did);
				check_value("bus_req.subdid", bus_req.subdid, exp.subdid);
				check_value("bus_req.addr", bus_req.addr, exp.addr);
				check_value("bus_req.len", bus_req.len, exp.len);
				check_value("bus_req.data", bus_req.data, exp.data);
				check_value("bus_req.mask", bus_req.mask, exp.mask);
				beat_idx++;
				if (beat_idx == cur_n)
					in_txn = 1'b0;
			end else if (!bus_valid && in_txn) begin
				faults++;
				$display("At %0t ns bus_valid dropped after %0d of %0d beats from device %0d",
					$time, beat_idx, cur_n, cur_did);
				repeat (cur_n - beat_idx) void'(exp_beats[cur_did].pop_front());
				in_txn = 1'b0;
			end
		end
	end

	initial begin : stimulus
		int row;
		int grp;
		int ret;
		rst_b = 1'b0;
		dev_valid = '0;
		bus_credit = 1'b0;
		for (int d = 0; d < DEVS; d++) begin
			dev_req[d] = '0;
			dev_cred[d] = fsab_arb_pkg::FSAB_DEV_CREDITS;
		end
		repeat (16) @(posedge clk);
		#1;
		rst_b = 1'b1;

		// Quiet bus while nobody pushes
		repeat (20) begin
			@(negedge clk);
			check_value("bus_valid", bus_valid, 1'b0);
			check_value("dev_credit", dev_credit, '0);
		end
		next_slot();

		row = 0;
		while (row < NUM_ROWS) begin
			grp = txn_table[row].group;
			ret = 0;
			while (row < NUM_ROWS && txn_table[row].group == grp) begin
				push_txn(row);
				ret += txn_table[row].ret;
				row++;
			end
			wait_quiet();
			release_credits(ret);
		end

		for (int d = 0; d < DEVS; d++) begin
			check_value($sformatf("dev_credit[%0d] pulses", d), credit_pulses[d], pushed_cnt[d]);
			check_value($sformatf("credits held by device %0d", d), dev_cred[d],
				fsab_arb_pkg::FSAB_DEV_CREDITS);
			check_value($sformatf("beats never seen from device %0d", d),
				exp_beats[d].size(), 0);
		end
		check_value("transactions on the bus", started_total, NUM_ROWS);

		$display("Checks done: %0d value mismatches, %0d other failures", errors, faults);
		if (errors == 0 && faults == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin : watchdog
		int limit;
		#1;
		limit = 40 * total_beats() + 2000;
		repeat (limit) @(posedge clk);
		$display("Timeout: the run did not finish within %0d clock cycles", limit);
		$display("Checks done: %0d value mismatches, %0d other failures", errors, faults);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- fsab_arbiter.f
+incdir+dv
verilog/fsab_bus_pkg.sv
verilog/fsab_arb_pkg.sv
verilog/fsab_req_fifo.sv
verilog/fsab_arb_select.sv
verilog/fsab_arbiter.sv
dv/fsab_arbiter_tb.sv

//--- verilog/fsab_arb_pkg.sv
// Arbiter configuration

package fsab_arb_pkg;

	// Requesting devices, any value from 1 up
	localparam int FSAB_DEVICES = 4;
	localparam int FSAB_DEV_W = (FSAB_DEVICES > 1) ? $clog2(FSAB_DEVICES) : 1;

	// Room for two maximal transactions per device
	localparam int FSAB_FIFO_BEATS = 2 * fsab_bus_pkg::FSAB_MAX_LEN;
	localparam int FSAB_FIFO_AW = $clog2(FSAB_FIFO_BEATS);

	// Credits handed out at reset
	localparam int FSAB_DEV_CREDITS = 2;
	localparam int FSAB_BUS_CREDITS = 4;

	// Complete transactions a buffer may hold, bounded by device credits
	localparam int FSAB_TRANS_W = $clog2(FSAB_DEV_CREDITS + 1);

	localparam int FSAB_BUS_CREDIT_W = $clog2(FSAB_BUS_CREDITS + 1);

endpackage

//--- verilog/fsab_arb_select.sv
`timescale 1ns/10ps

// Bus credit tracking, device selection and output routing
module fsab_arb_select (
	input  logic clk,
	input  logic rst_b,
	input  logic bus_credit,
	input  logic [fsab_arb_pkg::FSAB_DEVICES-1:0] ready,
	input  logic [fsab_arb_pkg::FSAB_DEVICES-1:0] active,
	output logic [fsab_arb_pkg::FSAB_DEVICES-1:0] start,
	input  logic [fsab_arb_pkg::FSAB_DEVICES-1:0] fifo_valid,
	input  fsab_bus_pkg::fsab_req_t fifo_req [fsab_arb_pkg::FSAB_DEVICES],
	output logic bus_valid,
	output fsab_bus_pkg::fsab_req_t bus_req
);

	logic [fsab_arb_pkg::FSAB_BUS_CREDIT_W-1:0] credits;
	logic credit_avail;

	logic [fsab_arb_pkg::FSAB_DEV_W-1:0] cur_dev; // Owner of the bus
	logic [fsab_arb_pkg::FSAB_DEV_W-1:0] next_dev;
	logic new_sel;

	assign credit_avail = credits != '0;
	assign new_sel = !active[cur_dev]; // Current owner done or never started

	// One credit in per target pulse, one out per start
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			credits <= fsab_arb_pkg::FSAB_BUS_CREDITS[fsab_arb_pkg::FSAB_BUS_CREDIT_W-1:0];
		end else if (bus_credit && !(|start)) begin
			credits <= credits + 1'b1;
		end else if (!bus_credit && (|start)) begin
			credits <= credits - 1'b1;
		end
	end

	// Fixed priority, highest numbered ready device wins
	always_comb begin
		next_dev = '0;
		for (int i = 0; i < fsab_arb_pkg::FSAB_DEVICES; i++) begin
			if (ready[i])
				next_dev = i[fsab_arb_pkg::FSAB_DEV_W-1:0];
		end
	end

	always_comb begin
		for (int i = 0; i < fsab_arb_pkg::FSAB_DEVICES; i++) begin
			start[i] = new_sel && next_dev == i[fsab_arb_pkg::FSAB_DEV_W-1:0] &&
				ready[i] && credit_avail;
		end
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			cur_dev <= '0;
		end else if (new_sel) begin
			cur_dev <= next_dev;
		end
	end

	// Leftover beats of an idle buffer are masked off
	assign bus_valid = fifo_valid[cur_dev] & active[cur_dev];
	assign bus_req = fifo_req[cur_dev];

endmodule

//--- verilog/fsab_arbiter.sv
`timescale 1ns/10ps

// FSAB request arbiter
module fsab_arbiter (
	input  logic clk,
	input  logic rst_b,
	input  logic [fsab_arb_pkg::FSAB_DEVICES-1:0] dev_valid,
	input  fsab_bus_pkg::fsab_req_t dev_req [fsab_arb_pkg::FSAB_DEVICES],
	output logic [fsab_arb_pkg::FSAB_DEVICES-1:0] dev_credit,
	output logic bus_valid,
	output fsab_bus_pkg::fsab_req_t bus_req,
	input  logic bus_credit
);

	logic [fsab_arb_pkg::FSAB_DEVICES-1:0] fifo_ready;
	logic [fsab_arb_pkg::FSAB_DEVICES-1:0] fifo_active;
	logic [fsab_arb_pkg::FSAB_DEVICES-1:0] fifo_start;
	logic [fsab_arb_pkg::FSAB_DEVICES-1:0] fifo_valid;
	fsab_bus_pkg::fsab_req_t fifo_req [fsab_arb_pkg::FSAB_DEVICES];

	// One buffer per device
	for (genvar i = 0; i < fsab_arb_pkg::FSAB_DEVICES; i++) begin : g_fifo
		fsab_req_fifo u_fifo (
			.clk        (clk),
			.rst_b      (rst_b),
			.in_valid   (dev_valid[i]),
			.in_req     (dev_req[i]),
			.dev_credit (dev_credit[i]),
			.start      (fifo_start[i]),
			.ready      (fifo_ready[i]),
			.active     (fifo_active[i]),
			.out_valid  (fifo_valid[i]),
			.out_req    (fifo_req[i])
		);
	end

	fsab_arb_select u_select (
		.clk        (clk),
		.rst_b      (rst_b),
		.bus_credit (bus_credit),
		.ready      (fifo_ready),
		.active     (fifo_active),
		.start      (fifo_start),
		.fifo_valid (fifo_valid),
		.fifo_req   (fifo_req),
		.bus_valid  (bus_valid),
		.bus_req    (bus_req)
	);

endmodule

//--- verilog/fsab_bus_pkg.sv
// FSAB request channel definitions, shared by devices, buffers and the bus

package fsab_bus_pkg;

	// Field widths
	localparam int FSAB_DID_W = 4;   // Device id and sub-id tag
	localparam int FSAB_ADDR_W = 31; // Word address
	localparam int FSAB_LEN_W = 4;
	localparam int FSAB_DATA_W = 64;
	localparam int FSAB_MASK_W = 8;  // One bit per data byte

	// Longest transaction in beats
	localparam int FSAB_MAX_LEN = 8;

	// A read is always a single beat; a write carries len beats
	typedef enum logic {
		FSAB_READ = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	// One request beat
	// Header fields hold steady across all beats of a transaction
	typedef struct packed {
		fsab_mode_e mode;
		logic [FSAB_DID_W-1:0] did;
		logic [FSAB_DID_W-1:0] subdid;
		logic [FSAB_ADDR_W-1:0] addr;
		logic [FSAB_LEN_W-1:0] len;   // 1 to FSAB_MAX_LEN
		logic [FSAB_DATA_W-1:0] data;
		logic [FSAB_MASK_W-1:0] mask;
	} fsab_req_t;

endpackage

//--- verilog/fsab_req_fifo.sv
`timescale 1ns/10ps

// Request buffer for one device
module fsab_req_fifo (
	input  logic clk,
	input  logic rst_b,
	input  logic in_valid,
	input  fsab_bus_pkg::fsab_req_t in_req,
	output logic dev_credit,
	input  logic start,
	output logic ready,
	output logic active,
	output logic out_valid,
	output fsab_bus_pkg::fsab_req_t out_req
);

	fsab_bus_pkg::fsab_req_t mem [fsab_arb_pkg::FSAB_FIFO_BEATS];

	logic [fsab_arb_pkg::FSAB_FIFO_AW-1:0] wr_idx;
	logic [fsab_arb_pkg::FSAB_FIFO_AW-1:0] rd_idx;
	logic wr_wrap; // Flips on each pass through the memory
	logic rd_wrap;

	logic [fsab_bus_pkg::FSAB_LEN_W-1:0] in_cnt; // Beats taken of the incoming transaction
	logic in_last;

	logic [fsab_arb_pkg::FSAB_TRANS_W-1:0] trans_cnt;
	logic [fsab_bus_pkg::FSAB_LEN_W-1:0] beats_left;
	logic [fsab_bus_pkg::FSAB_LEN_W-1:0] head_len;
	logic tx_last;

	function automatic logic [fsab_arb_pkg::FSAB_FIFO_AW-1:0] idx_next(
		input logic [fsab_arb_pkg::FSAB_FIFO_AW-1:0] idx
	);
		if (idx == fsab_arb_pkg::FSAB_FIFO_BEATS - 1)
			return '0;
		return idx + 1'b1;
	endfunction

	// Last beat of an incoming transaction, from its own mode and length
	assign in_last = in_valid &&
		(in_req.mode == fsab_bus_pkg::FSAB_READ || in_cnt == in_req.len - 1'b1);

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			in_cnt <= '0;
		end else if (in_valid) begin
			in_cnt <= in_last ? '0 : in_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_idx] <= in_req;
	end

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			wr_idx <= '0;
			wr_wrap <= 1'b0;
		end else if (in_valid) begin
			wr_idx <= idx_next(wr_idx);
			if (wr_idx == fsab_arb_pkg::FSAB_FIFO_BEATS - 1)
				wr_wrap <= !wr_wrap;
		end
	end

	// Oldest stored beat, always on view
	assign out_req = mem[rd_idx];
	assign out_valid = (wr_idx != rd_idx) || (wr_wrap != rd_wrap);

	// Beat count of the transaction at the head
	assign head_len = (out_req.mode == fsab_bus_pkg::FSAB_WRITE) ?
		out_req.len : fsab_bus_pkg::FSAB_LEN_W'(1);

	assign tx_last = active && beats_left == 1;
	assign ready = trans_cnt != '0;

	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			active <= 1'b0;
			beats_left <= '0;
			dev_credit <= 1'b0;
			rd_idx <= '0;
			rd_wrap <= 1'b0;
		end else begin
			dev_credit <= tx_last; // Credit goes back as ownership ends
			if (start) begin
				active <= 1'b1;
				beats_left <= head_len;
			end else if (active) begin
				rd_idx <= idx_next(rd_idx);
				if (rd_idx == fsab_arb_pkg::FSAB_FIFO_BEATS - 1)
					rd_wrap <= !rd_wrap;
				beats_left <= beats_left - 1'b1;
				if (tx_last)
					active <= 1'b0;
			end
		end
	end

	// Complete transactions held, in and out may land together
	always_ff @(posedge clk or negedge rst_b) begin
		if (!rst_b) begin
			trans_cnt <= '0;
		end else begin
			case ({in_last, tx_last})
				2'b10: trans_cnt <= trans_cnt + 1'b1;
				2'b01: trans_cnt <= trans_cnt - 1'b1;
				default: trans_cnt <= trans_cnt;
			endcase
		end
	end

endmodule
